//--- band_vector_doa.f
+incdir+verilog
verilog/doa_stream_pkg.sv
verilog/doa_result_pkg.sv
verilog/band_correlator.sv
verilog/sync_fifo.sv
verilog/isqrt_unit.sv
verilog/eigen_solver.sv
verilog/result_port.sv
verilog/band_vector_doa.sv
verification/band_vector_doa_tb.sv

//--- verification/band_vector_doa_tb.sv
`timescale 1ns/1ps
`include "doa_consts.svh"

module band_vector_doa_tb
    import doa_stream_pkg::*;
    import doa_result_pkg::*;
();

    localparam int FRAME_CYCLES    = `DOA_VECTOR_LEN / `DOA_LANES;
    localparam int DIN_W           = `DOA_DIN_WIDTH;
    localparam int N_FRAMES        = 13;  // frames sent over all tests
    localparam int WATCHDOG_CYCLES = N_FRAMES * 2000 + 10000;

    logic          clk;
    logic          rst_n;
    lane_vec_t     din1, din2;
    logic          din_valid;
    logic          new_acc;
    logic          out_req;
    logic          out_ack;
    eigen_result_t out_data;
    logic          overflow;

    eigen_result_t exp_q [$];  // expected results in band order
    lane_vec_t     frame1 [FRAME_CYCLES];
    lane_vec_t     frame2 [FRAME_CYCLES];
    int            err_cnt;
    int            chk_cnt;
    int            ack_delay_max;
    bit            discard;    // results not checked while set
    int            seed_val;
    logic          req_prev;

    band_vector_doa band_vector_doa_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .din1      (din1),
        .din2      (din2),
        .din_valid (din_valid),
        .new_acc   (new_acc),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_data  (out_data),
        .overflow  (overflow)
    );

    always #5 clk = ~clk;

    // bitwise floor root, largest r with r*r <= v
    function automatic logic [127:0] floor_sqrt(input logic [127:0] v);
        logic [127:0] r;
        logic [127:0] t;
        r = '0;
        for (int k = `DOA_ROOT_WIDTH - 1; k >= 0; k--) begin
            t = r | (128'd1 << k);
            if (t * t <= v)
                r = t;
        end
        return r;
    endfunction

    // reference eigen result of one band of the current frame
    function automatic eigen_result_t model_band(input int band);
        eigen_result_t       e;
        logic signed [127:0] a, b, c, d;
        logic signed [127:0] r11, r22, xre, xim;
        logic signed [127:0] half_tr, half_df, rad, root, lamb1, lamb2;
        int                  cyc;
        r11 = 0;
        r22 = 0;
        xre = 0;
        xim = 0;
        for (int k = 0; k < `DOA_BAND_CYCLES; k++) begin
            cyc = band * `DOA_BAND_CYCLES + k;
            for (int l = 0; l < `DOA_LANES; l++) begin
                a = $signed(frame1[cyc][l].re);
                b = $signed(frame1[cyc][l].im);
                c = $signed(frame2[cyc][l].re);
                d = $signed(frame2[cyc][l].im);
                r11 = r11 + a * a + b * b;
                r22 = r22 + c * c + d * d;
                xre = xre + a * c + b * d;  // x1 * conj(x2)
                xim = xim + b * c - a * d;
            end
        end
        half_tr = (r11 + r22) >>> 1;
        half_df = (r11 - r22) >>> 1;
        rad     = half_df * half_df + xre * xre + xim * xim;
        root    = floor_sqrt(rad);
        lamb1   = half_tr + root;
        lamb2   = half_tr - root;
        e.lamb1      = lamb1[`DOA_OUT_WIDTH-1:0];
        e.lamb2      = lamb2[`DOA_OUT_WIDTH-1:0];
        e.eigen1_y   = (lamb1 - r11) & {`DOA_OUT_WIDTH{1'b1}};
        e.eigen2_y   = (lamb2 - r11) & {`DOA_OUT_WIDTH{1'b1}};
        e.eigen_x_re = xre[`DOA_OUT_WIDTH-1:0];
        e.eigen_x_im = xim[`DOA_OUT_WIDTH-1:0];
        e.error      = (xre == 0) && (xim == 0);
        e.band       = band_idx_t'(band);
        return e;
    endfunction

    task automatic compare_field(input string name, input int band,
                                 input logic [`DOA_OUT_WIDTH-1:0] want,
                                 input logic [`DOA_OUT_WIDTH-1:0] got);
        if (got !== want) begin
            err_cnt++;
            $display("[FAIL] band %0d %s: expected %h, got %h", band, name, want, got);
        end
    endtask

    task automatic check_result(input eigen_result_t want, input eigen_result_t got);
        chk_cnt++;
        compare_field("band", want.band, `DOA_OUT_WIDTH'(want.band), `DOA_OUT_WIDTH'(got.band));
        compare_field("lamb1", want.band, want.lamb1, got.lamb1);
        compare_field("lamb2", want.band, want.lamb2, got.lamb2);
        compare_field("eigen1_y", want.band, want.eigen1_y, got.eigen1_y);
        compare_field("eigen2_y", want.band, want.eigen2_y, got.eigen2_y);
        compare_field("eigen_x_re", want.band, want.eigen_x_re, got.eigen_x_re);
        compare_field("eigen_x_im", want.band, want.eigen_x_im, got.eigen_x_im);
        compare_field("error", want.band, `DOA_OUT_WIDTH'(want.error),
                      `DOA_OUT_WIDTH'(got.error));
    endtask

    task automatic check_flag(input string name, input logic want, input logic got);
        chk_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("[FAIL] %s: expected %h, got %h", name, want, got);
        end
    endtask

    // one frame: new_acc, then the valid cycles with optional holes
    task automatic send_frame(input int gap_max, input bit keep_expect);
        int gap;
        if (keep_expect) begin
            for (int b = 0; b < `DOA_BANDS; b++)
                exp_q.push_back(model_band(b));
        end
        @(posedge clk);
        new_acc   <= 1'b1;
        din_valid <= 1'b0;
        for (int cyc = 0; cyc < FRAME_CYCLES; cyc++) begin
            gap = (gap_max > 0) ? $urandom_range(0, gap_max) : 0;
            repeat (gap) begin
                @(posedge clk);
                new_acc   <= 1'b0;
                din_valid <= 1'b0;
            end
            @(posedge clk);
            new_acc   <= 1'b0;
            din1      <= frame1[cyc];
            din2      <= frame2[cyc];
            din_valid <= 1'b1;
        end
        @(posedge clk);
        din_valid <= 1'b0;
    endtask

    // one full four-phase cycle on the output port
    task automatic host_ack();
        eigen_result_t got;
        int            delay;
        @(negedge clk);
        while (out_req !== 1'b1)
            @(negedge clk);
        got   = out_data;
        delay = (ack_delay_max > 0) ? $urandom_range(0, ack_delay_max) : 0;
        repeat (delay) @(negedge clk);
        if (out_data !== got) begin
            err_cnt++;
            $display("out_data changed while out_req was high");
        end
        @(posedge clk);
        out_ack <= 1'b1;
        if (!discard) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("result for band %0d arrived with none expected", got.band);
            end else begin
                check_result(exp_q.pop_front(), got);
            end
        end
        @(negedge clk);
        while (out_req)
            @(negedge clk);
        @(posedge clk);
        out_ack <= 1'b0;
    endtask

    // all expected results taken and the port idle
    task automatic wait_drain();
        @(negedge clk);
        while (exp_q.size() != 0 || out_req || out_ack)
            @(negedge clk);
    endtask

    task automatic fill_phase_frame();
        int ch;
        for (int c = 0; c < FRAME_CYCLES; c++) begin
            for (int l = 0; l < `DOA_LANES; l++) begin
                ch = c * `DOA_LANES + l;
                frame1[c][l].re = DIN_W'(37 * ch - 1000);
                frame1[c][l].im = DIN_W'(800 - 29 * ch);
                frame2[c][l].re = DIN_W'(29 * ch - 800);  // x2 = j * x1
                frame2[c][l].im = DIN_W'(37 * ch - 1000);
            end
        end
    endtask

    task automatic fill_random_frame();
        for (int c = 0; c < FRAME_CYCLES; c++) begin
            for (int l = 0; l < `DOA_LANES; l++) begin
                frame1[c][l].re = DIN_W'($urandom);
                frame1[c][l].im = DIN_W'($urandom);
                frame2[c][l].re = DIN_W'($urandom);
                frame2[c][l].im = DIN_W'($urandom);
            end
        end
    endtask

    task automatic test_single_frame();
        ack_delay_max = 0;
        fill_phase_frame();
        send_frame(0, 1'b1);
        wait_drain();
    endtask

    task automatic test_zero_antenna();
        ack_delay_max = 0;
        for (int c = 0; c < FRAME_CYCLES; c++) begin
            for (int l = 0; l < `DOA_LANES; l++) begin
                // even samples keep r11 even, so lamb1 comes out equal to r11
                frame1[c][l].re = DIN_W'(2 * (11 * (c * `DOA_LANES + l) - 300));
                frame1[c][l].im = DIN_W'(2 * (150 - 7 * (c * `DOA_LANES + l)));
                frame2[c][l]    = '0;
            end
        end
        send_frame(0, 1'b1);
        wait_drain();
    endtask

    task automatic test_random_gaps();
        ack_delay_max = 5;
        repeat (4) begin
            fill_random_frame();
            send_frame(3, 1'b1);
            wait_drain();
        end
    endtask

    task automatic test_slow_host();
        ack_delay_max = 200;
        fill_random_frame();
        send_frame(0, 1'b1);
        fill_random_frame();
        send_frame(0, 1'b1);
        wait_drain();
        check_flag("overflow", 1'b0, overflow);
    endtask

    task automatic test_overflow();
        ack_delay_max = 0;
        fill_random_frame();
        send_frame(0, 1'b1);
        fill_random_frame();
        send_frame(0, 1'b1);  // 8 bands fit the sums FIFO
        wait_drain();
        check_flag("overflow", 1'b0, overflow);
        discard = 1'b1;
        repeat (3) begin
            fill_random_frame();
            send_frame(0, 1'b0);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_flag("overflow", 1'b1, overflow);
    endtask

    // out_req must not rise before the host has dropped out_ack
    always @(negedge clk) begin
        if (rst_n && out_req && !req_prev && out_ack) begin
            err_cnt++;
            $display("out_req rose while out_ack was still high");
        end
        req_prev = out_req;
    end

    initial begin
        forever host_ack();
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, results still outstanding", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        seed_val      = $urandom(86693);
        clk           = 1'b0;
        rst_n         = 1'b0;
        din1          = '0;
        din2          = '0;
        din_valid     = 1'b0;
        new_acc       = 1'b0;
        out_ack       = 1'b0;
        err_cnt       = 0;
        chk_cnt       = 0;
        ack_delay_max = 0;
        discard       = 1'b0;
        req_prev      = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_flag("overflow", 1'b0, overflow);
        test_single_frame();
        test_zero_antenna();
        test_random_gaps();
        test_slow_host();
        test_overflow();
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verilog/band_correlator.sv
`timescale 1ns/1ps
`include "doa_consts.svh"

module band_correlator
    import doa_stream_pkg::*;
    import doa_result_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  lane_vec_t  din1,
    input  lane_vec_t  din2,
    input  logic       din_valid,
    input  logic       new_acc,
    output logic       sums_push,
    output corr_sums_t sums
);

    localparam int CNT_W  = $clog2(`DOA_BAND_CYCLES);
    localparam int PROD_W = 2 * `DOA_DIN_WIDTH;

    logic [CNT_W-1:0] cyc_cnt;
    band_idx_t        band_cnt;
    logic             band_last;

    logic signed [`DOA_ACC_WIDTH-1:0] lane_r11, lane_r22, lane_re, lane_im;
    logic signed [`DOA_ACC_WIDTH-1:0] acc_r11, acc_r22, acc_re, acc_im;

    // products of every lane, summed across the lanes
    always_comb begin
        logic signed [`DOA_DIN_WIDTH-1:0] a, b, c, d;
        logic signed [PROD_W-1:0]         aa, bb, cc, dd, ac, bd, bc, ad;
        lane_r11 = '0;
        lane_r22 = '0;
        lane_re  = '0;
        lane_im  = '0;
        for (int i = 0; i < `DOA_LANES; i++) begin
            a  = din1[i].re;  // x1 = a + jb
            b  = din1[i].im;
            c  = din2[i].re;  // x2 = c + jd
            d  = din2[i].im;
            aa = a * a;
            bb = b * b;
            cc = c * c;
            dd = d * d;
            ac = a * c;
            bd = b * d;
            bc = b * c;
            ad = a * d;
            lane_r11 = lane_r11 + aa + bb;
            lane_r22 = lane_r22 + cc + dd;
            lane_re  = lane_re + ac + bd;  // (a+jb)(c-jd)
            lane_im  = lane_im + bc - ad;
        end
    end

    assign band_last = din_valid && (cyc_cnt == CNT_W'(`DOA_BAND_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cyc_cnt   <= '0;
            band_cnt  <= '0;
            sums_push <= 1'b0;
        end else begin
            sums_push <= 1'b0;
            if (new_acc) begin
                cyc_cnt  <= '0;
                band_cnt <= '0;
            end else if (band_last) begin
                cyc_cnt   <= '0;
                band_cnt  <= band_cnt + 1'b1;
                sums_push <= 1'b1;  // one cycle after the band's last channel
            end else if (din_valid) begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_acc || band_last) begin
            acc_r11 <= '0;
            acc_r22 <= '0;
            acc_re  <= '0;
            acc_im  <= '0;
        end else if (din_valid) begin
            acc_r11 <= acc_r11 + lane_r11;
            acc_r22 <= acc_r22 + lane_r22;
            acc_re  <= acc_re + lane_re;
            acc_im  <= acc_im + lane_im;
        end
        if (!new_acc && band_last) begin
            sums.r11    <= acc_r11 + lane_r11;  // include the last cycle
            sums.r22    <= acc_r22 + lane_r22;
            sums.r12_re <= acc_re + lane_re;
            sums.r12_im <= acc_im + lane_im;
            sums.band   <= band_cnt;
        end
    end

endmodule

//--- verilog/band_vector_doa.sv
`timescale 1ns/1ps
`include "doa_consts.svh"

module band_vector_doa
    import doa_stream_pkg::*;
    import doa_result_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  lane_vec_t     din1,
    input  lane_vec_t     din2,
    input  logic          din_valid,
    input  logic          new_acc,
    output logic          out_req,
    input  logic          out_ack,
    output eigen_result_t out_data,
    output logic          overflow
);

    logic          sums_push;
    corr_sums_t    sums_in;
    logic          sums_valid, sums_ready;
    corr_sums_t    sums_head;
    logic          res_valid, res_full;
    eigen_result_t res_in;
    logic          port_valid, port_ready;
    eigen_result_t res_head;

    band_correlator band_correlator_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .din1      (din1),
        .din2      (din2),
        .din_valid (din_valid),
        .new_acc   (new_acc),
        .sums_push (sums_push),
        .sums      (sums_in)
    );

    // no back-pressure towards the stream, full only counts drops
    sync_fifo #(.item_t(corr_sums_t), .DEPTH(`DOA_SUM_DEPTH)) sums_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (sums_push),
        .push_data (sums_in),
        .full      (),
        .out_valid (sums_valid),
        .out_ready (sums_ready),
        .out_data  (sums_head),
        .overflow  (overflow)
    );

    eigen_solver eigen_solver_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sums_valid (sums_valid),
        .sums_ready (sums_ready),
        .sums       (sums_head),
        .res_valid  (res_valid),
        .res_ready  (!res_full),
        .res        (res_in)
    );

    sync_fifo #(.item_t(eigen_result_t), .DEPTH(`DOA_RES_DEPTH)) res_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (res_valid),
        .push_data (res_in),
        .full      (res_full),
        .out_valid (port_valid),
        .out_ready (port_ready),
        .out_data  (res_head),
        .overflow  ()
    );

    result_port result_port_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (port_valid),
        .in_ready (port_ready),
        .in_data  (res_head),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data)
    );

endmodule

//--- verilog/doa_consts.svh
`ifndef DOA_CONSTS_SVH
`define DOA_CONSTS_SVH

// input stream
`define DOA_DIN_WIDTH    16  // signed, per re/im component
`define DOA_LANES        4   // channels per clock
`define DOA_VECTOR_LEN   64  // channels per frame
`define DOA_BANDS        4   // bands per frame

// valid cycles that make up one band
`define DOA_BAND_CYCLES  (`DOA_VECTOR_LEN / `DOA_LANES / `DOA_BANDS)

// correlation sums, signed
`define DOA_ACC_WIDTH    40

// eigen solver datapath
`define DOA_RAD_WIDTH    82  // radicand, twice the root width
`define DOA_ROOT_WIDTH   41
`define DOA_OUT_WIDTH    42  // signed result fields

// buffering
`define DOA_SUM_DEPTH    8   // band sums waiting for the solver
`define DOA_RES_DEPTH    4   // results waiting for the host

`endif

//--- verilog/doa_result_pkg.sv
`include "doa_consts.svh"

package doa_result_pkg;

    import doa_stream_pkg::band_idx_t;

    // correlation terms of one band
    typedef struct packed {
        logic signed [`DOA_ACC_WIDTH-1:0] r11;     // sum |x1|^2
        logic signed [`DOA_ACC_WIDTH-1:0] r22;     // sum |x2|^2
        logic signed [`DOA_ACC_WIDTH-1:0] r12_re;  // sum x1 * conj(x2)
        logic signed [`DOA_ACC_WIDTH-1:0] r12_im;
        band_idx_t                        band;
    } corr_sums_t;

    // eigen decomposition of one band, vectors left unnormalised
    typedef struct packed {
        logic signed [`DOA_OUT_WIDTH-1:0] lamb1;
        logic signed [`DOA_OUT_WIDTH-1:0] lamb2;
        logic signed [`DOA_OUT_WIDTH-1:0] eigen1_y;    // lamb1 - r11
        logic signed [`DOA_OUT_WIDTH-1:0] eigen2_y;    // lamb2 - r11
        logic signed [`DOA_OUT_WIDTH-1:0] eigen_x_re;  // r12
        logic signed [`DOA_OUT_WIDTH-1:0] eigen_x_im;
        logic                             error;       // r12 == 0, degenerate
        band_idx_t                        band;
    } eigen_result_t;

endpackage

//--- verilog/doa_stream_pkg.sv
`include "doa_consts.svh"

package doa_stream_pkg;

    // one complex FFT channel
    typedef struct packed {
        logic signed [`DOA_DIN_WIDTH-1:0] re;
        logic signed [`DOA_DIN_WIDTH-1:0] im;
    } cplx_t;

    // all lanes of one antenna in one clock, lane 0 in the low bits
    typedef cplx_t [`DOA_LANES-1:0] lane_vec_t;

    typedef logic [$clog2(`DOA_BANDS)-1:0] band_idx_t;

endpackage

//--- verilog/eigen_solver.sv
`timescale 1ns/1ps
`include "doa_consts.svh"

module eigen_solver
    import doa_stream_pkg::*;
    import doa_result_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          sums_valid,
    output logic          sums_ready,
    input  corr_sums_t    sums,
    output logic          res_valid,
    input  logic          res_ready,
    output eigen_result_t res
);

    localparam int AW = `DOA_ACC_WIDTH;

    typedef enum logic [2:0] {
        S_IDLE,
        S_HALF,
        S_RAD,
        S_WAIT,
        S_EIG,
        S_OUT
    } state_t;

    state_t state;

    logic signed [AW-1:0]              r11_q, r22_q, re_q, im_q;
    band_idx_t                         band_q;
    logic signed [AW:0]                half_tr, half_df;
    logic [`DOA_RAD_WIDTH-1:0]         rad_q;
    logic signed [`DOA_OUT_WIDTH-1:0]  lamb1_q, lamb2_q;
    logic                              sqrt_start, sqrt_busy, sqrt_done;
    logic [`DOA_ROOT_WIDTH-1:0]        sqrt_root;

    assign sums_ready = (state == S_IDLE);
    assign res_valid  = (state == S_OUT);  // held until the result FIFO takes it

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            sqrt_start <= 1'b0;
        end else begin
            sqrt_start <= 1'b0;
            case (state)
                S_IDLE: if (sums_valid) state <= S_HALF;
                S_HALF: state <= S_RAD;
                S_RAD: begin
                    if (!sqrt_busy) begin
                        sqrt_start <= 1'b1;
                        state      <= S_WAIT;
                    end
                end
                S_WAIT: if (sqrt_done) state <= S_EIG;
                S_EIG: state <= S_OUT;
                S_OUT: if (res_ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (sums_valid) begin
                    r11_q  <= sums.r11;
                    r22_q  <= sums.r22;
                    re_q   <= sums.r12_re;
                    im_q   <= sums.r12_im;
                    band_q <= sums.band;
                end
            end
            S_HALF: begin
                half_tr <= (r11_q + r22_q) >>> 1;
                half_df <= (r11_q - r22_q) >>> 1;
            end
            S_RAD: rad_q <= half_df * half_df + re_q * re_q + im_q * im_q;
            S_WAIT: begin
                if (sqrt_done) begin
                    lamb1_q <= half_tr + $signed({1'b0, sqrt_root});
                    lamb2_q <= half_tr - $signed({1'b0, sqrt_root});
                end
            end
            S_EIG: begin
                res.lamb1      <= lamb1_q;
                res.lamb2      <= lamb2_q;
                res.eigen1_y   <= lamb1_q - r11_q;
                res.eigen2_y   <= lamb2_q - r11_q;
                res.eigen_x_re <= re_q;  // sign extended
                res.eigen_x_im <= im_q;
                res.error      <= (re_q == '0) && (im_q == '0);
                res.band       <= band_q;
            end
            default: ;
        endcase
    end

    isqrt_unit isqrt_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (sqrt_start),
        .radicand (rad_q),
        .busy     (sqrt_busy),
        .done     (sqrt_done),
        .root     (sqrt_root)
    );

endmodule

//--- verilog/isqrt_unit.sv
`timescale 1ns/1ps
`include "doa_consts.svh"

module isqrt_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic [`DOA_RAD_WIDTH-1:0]  radicand,
    output logic                       busy,
    output logic                       done,
    output logic [`DOA_ROOT_WIDTH-1:0] root
);

    localparam int RW    = `DOA_RAD_WIDTH;
    localparam int QW    = `DOA_ROOT_WIDTH;
    localparam int REM_W = QW + 3;  // partial remainder never exceeds 2q plus a bit pair
    localparam int CNT_W = $clog2(QW + 1);

    logic [RW-1:0]    rad_sh;
    logic [REM_W-1:0] rem, rem_sh, trial;
    logic [QW-1:0]    q, q_next;
    logic [CNT_W-1:0] bits_left;
    logic             fits;

    // one restoring step, next bit pair of the radicand
    always_comb begin
        rem_sh = {rem[REM_W-3:0], rad_sh[RW-1 -: 2]};
        trial  = REM_W'({q, 2'b01});  // 4q + 1
        fits   = (rem_sh >= trial);
        q_next = {q[QW-2:0], fits};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            bits_left <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy      <= 1'b1;
                bits_left <= CNT_W'(QW);
            end else if (busy) begin
                bits_left <= bits_left - 1'b1;
                if (bits_left == CNT_W'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            rad_sh <= radicand;
            rem    <= '0;
            q      <= '0;
        end else if (busy) begin
            rad_sh <= rad_sh << 2;
            rem    <= fits ? rem_sh - trial : rem_sh;
            q      <= q_next;
            if (bits_left == CNT_W'(1))
                root <= q_next;  // floor root, valid with done
        end
    end

endmodule

//--- verilog/result_port.sv
`timescale 1ns/1ps

module result_port
    import doa_result_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    output logic          in_ready,
    input  eigen_result_t in_data,
    output logic          out_req,
    input  logic          out_ack,
    output eigen_result_t out_data
);

    typedef enum logic [1:0] {
        P_IDLE,     // waiting for an entry, ack low
        P_REQ,      // req high, data held
        P_RELEASE   // req dropped, waiting for ack to fall
    } phase_t;

    phase_t phase;

    assign in_ready = (phase == P_IDLE) && !out_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase   <= P_IDLE;
            out_req <= 1'b0;
        end else begin
            case (phase)
                P_IDLE: begin
                    if (in_valid && in_ready) begin
                        phase   <= P_REQ;
                        out_req <= 1'b1;
                    end
                end
                P_REQ: begin
                    if (out_ack) begin
                        phase   <= P_RELEASE;
                        out_req <= 1'b0;
                    end
                end
                P_RELEASE: if (!out_ack) phase <= P_IDLE;
                default: phase <= P_IDLE;
            endcase
        end
    end

    // holding register, stable for the whole req phase
    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            out_data <= in_data;
    end

endmodule

//--- verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  item_t push_data,
    output logic  full,
    output logic  out_valid,
    input  logic  out_ready,
    output item_t out_data,
    output logic  overflow
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    item_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] count;
    logic          do_push, do_pop;

    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = (count == CW'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];  // head is visible the cycle after the push
    assign do_push   = push && !full;  // a push into a full buffer is lost
    assign do_pop    = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= ptr_next(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_next(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
            if (push && full)
                overflow <= 1'b1;  // sticky until reset
        end
    end

endmodule
